// File: design/tmu_pkg.sv
// shared widths and stage payloads for the vertex division pipeline.
// coordinates are signed 18 bit, difference magnitudes unsigned 17 bit.
// a difference wider than 17 bits of magnitude is truncated, keep inputs in range.
// the divisor is the destination square height, 11 bits, zero is allowed.

package tmu_pkg;

	// texture space coordinate, integer texel units.
	typedef logic signed [17:0] coord_t;

	// difference magnitude, also quotient and remainder.
	typedef logic [16:0] mag_t;

	// per pixel delta.
	typedef logic signed [11:0] delta_t;

	// destination square height, the divisor.
	typedef logic [10:0] height_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} vertex_t;

	// sign and magnitude of one vertical difference.
	typedef struct packed {
		logic positive;
		mag_t mag;
	} diff_t;

	// per line step for one difference.
	typedef struct packed {
		logic positive;
		mag_t q;
		mag_t r;
	} divres_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage payloads
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// a and b on the top edge, c below a, d below b.
	typedef struct packed {
		vertex_t a;
		vertex_t b;
		vertex_t c;
		vertex_t d;
		delta_t drx;
		delta_t dry;
		height_t squareh;
	} square_t;

	typedef struct packed {
		vertex_t a;
		vertex_t b;
		diff_t cx;
		diff_t cy;
		diff_t dx;
		diff_t dy;
		delta_t drx;
		delta_t dry;
		height_t squareh;
	} vdivops_t;

	typedef struct packed {
		vertex_t a;
		vertex_t b;
		divres_t cx;
		divres_t cy;
		divres_t dx;
		divres_t dy;
		delta_t drx;
		delta_t dry;
	} vdiv_res_t;

endpackage

// File: design/tmu_divider17.sv
// restoring divider, 17 bit dividend by 11 bit divisor, one bit per cycle.
// operands are latched on start, results hold until the next start.
// a zero divisor gives an all-ones quotient and the dividend as remainder.
`timescale 1ns/1ps

module tmu_divider17 (
	input  logic             sys_clk,
	input  logic             sys_rst,

	input  logic             start_i,
	input  tmu_pkg::mag_t    dividend_i,
	input  tmu_pkg::height_t divisor_i,

	output logic             ready_o,
	output tmu_pkg::mag_t    quotient_o,
	output tmu_pkg::mag_t    remainder_o
);

	logic [4:0]       cnt;
	tmu_pkg::mag_t    quo;
	tmu_pkg::mag_t    rem;
	tmu_pkg::height_t div_q;
	logic [17:0]      trial;
	logic [17:0]      diff;
	logic             fits;

	// partial remainder with the next dividend bit shifted in.
	always_comb begin
		trial = {rem, quo[16]};
		fits = trial >= {7'd0, div_q};
		diff = trial - {7'd0, div_q};
	end

	// steps left, zero means done.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			cnt <= 5'd0;
		end else if (start_i) begin
			cnt <= 5'd17;
		end else if (cnt != 5'd0) begin
			cnt <= cnt - 5'd1;
		end
	end

	// dividend bits leave at the top, quotient bits enter at the bottom.
	always_ff @(posedge sys_clk) begin
		if (start_i) begin
			quo <= dividend_i;
			rem <= '0;
			div_q <= divisor_i;
		end else if (cnt != 5'd0) begin
			quo <= {quo[15:0], fits};
			rem <= fits ? diff[16:0] : trial[16:0];
		end
	end

	assign ready_o = (cnt == 5'd0);
	assign quotient_o = quo;
	assign remainder_o = rem;

endmodule

// File: design/tmu_vdivops.sv
// operand stage, one register slot with a strobe/acknowledge pair.
// differences are c-a and d-b, stored as sign plus 17 bit magnitude.
// magnitudes above 17 bits are silently truncated.
`timescale 1ns/1ps

module tmu_vdivops (
	input  logic              sys_clk,
	input  logic              sys_rst,

	input  logic              stb_i,
	output logic              ack_o,
	input  tmu_pkg::square_t  sq_i,

	output logic              stb_o,
	input  logic              ack_i,
	output tmu_pkg::vdivops_t ops_o
);

	// signed difference hi-lo as sign flag and magnitude.
	function automatic tmu_pkg::diff_t make_diff(
		input tmu_pkg::coord_t hi,
		input tmu_pkg::coord_t lo
	);
		logic [18:0] d;
		logic [18:0] m;
		tmu_pkg::diff_t res;
		d = {hi[17], hi} - {lo[17], lo};
		m = d[18] ? (19'd0 - d) : d;
		res.positive = ~d[18];
		res.mag = m[16:0];
		return res;
	endfunction

	logic              slot_full;
	logic              take;
	tmu_pkg::vdivops_t ops_d;
	tmu_pkg::vdivops_t slot_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// operand formation
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		ops_d.a = sq_i.a;
		ops_d.b = sq_i.b;
		ops_d.cx = make_diff(sq_i.c.x, sq_i.a.x);
		ops_d.cy = make_diff(sq_i.c.y, sq_i.a.y);
		ops_d.dx = make_diff(sq_i.d.x, sq_i.b.x);
		ops_d.dy = make_diff(sq_i.d.y, sq_i.b.y);
		ops_d.drx = sq_i.drx;
		ops_d.dry = sq_i.dry;
		ops_d.squareh = sq_i.squareh;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// register slot
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// free when empty or drained this cycle.
	assign ack_o = ~slot_full | ack_i;
	assign take = stb_i & ack_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			slot_full <= 1'b0;
		end else if (take) begin
			slot_full <= 1'b1;
		end else if (ack_i) begin
			slot_full <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (take) begin
			slot_q <= ops_d;
		end
	end

	assign stb_o = slot_full;
	assign ops_o = slot_q;

endmodule

// File: design/tmu_vdiv.sv
// division stage, four dividers in lockstep by the square height.
// accepts one square per division, ack_o is high only when idle.
// results appear 17 cycles after the accept edge and hold until acknowledged.
// the input payload may change after the accept edge.
`timescale 1ns/1ps

module tmu_vdiv (
	input  logic               sys_clk,
	input  logic               sys_rst,

	output logic               busy_o,

	input  logic               stb_i,
	output logic               ack_o,
	input  tmu_pkg::vdivops_t  ops_i,

	output logic               stb_o,
	input  logic               ack_i,
	output tmu_pkg::vdiv_res_t res_o
);

	typedef enum logic {
		S_IDLE,
		S_WAIT
	} state_t;

	state_t state;
	state_t state_next;

	logic start;
	logic ready;

	tmu_pkg::mag_t cx_q, cx_r;
	tmu_pkg::mag_t cy_q, cy_r;
	tmu_pkg::mag_t dx_q, dx_r;
	tmu_pkg::mag_t dy_q, dy_r;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// divider bank
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// all four finish together, only the first ready is watched.
	tmu_divider17 u_div_cx (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.start_i     (start),
		.dividend_i  (ops_i.cx.mag),
		.divisor_i   (ops_i.squareh),
		.ready_o     (ready),
		.quotient_o  (cx_q),
		.remainder_o (cx_r)
	);

	tmu_divider17 u_div_cy (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.start_i     (start),
		.dividend_i  (ops_i.cy.mag),
		.divisor_i   (ops_i.squareh),
		.ready_o     (),
		.quotient_o  (cy_q),
		.remainder_o (cy_r)
	);

	tmu_divider17 u_div_dx (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.start_i     (start),
		.dividend_i  (ops_i.dx.mag),
		.divisor_i   (ops_i.squareh),
		.ready_o     (),
		.quotient_o  (dx_q),
		.remainder_o (dx_r)
	);

	tmu_divider17 u_div_dy (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.start_i     (start),
		.dividend_i  (ops_i.dy.mag),
		.divisor_i   (ops_i.squareh),
		.ready_o     (),
		.quotient_o  (dy_q),
		.remainder_o (dy_r)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// forwarded fields
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	tmu_pkg::vertex_t a_f;
	tmu_pkg::vertex_t b_f;
	tmu_pkg::delta_t  drx_f;
	tmu_pkg::delta_t  dry_f;
	logic [3:0]       pos_f;

	always_ff @(posedge sys_clk) begin
		if (start) begin
			a_f <= ops_i.a;
			b_f <= ops_i.b;
			drx_f <= ops_i.drx;
			dry_f <= ops_i.dry;
			pos_f <= {ops_i.cx.positive, ops_i.cy.positive,
				ops_i.dx.positive, ops_i.dy.positive};
		end
	end

	always_comb begin
		res_o.a = a_f;
		res_o.b = b_f;
		res_o.cx = '{positive: pos_f[3], q: cx_q, r: cx_r};
		res_o.cy = '{positive: pos_f[2], q: cy_q, r: cy_r};
		res_o.dx = '{positive: pos_f[1], q: dx_q, r: dx_r};
		res_o.dy = '{positive: pos_f[0], q: dy_q, r: dy_r};
		res_o.drx = drx_f;
		res_o.dry = dry_f;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// controller
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= S_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			S_IDLE: begin
				if (stb_i) begin
					state_next = S_WAIT;
				end
			end
			S_WAIT: begin
				if (ready & ack_i) begin
					state_next = S_IDLE;
				end
			end
			default: state_next = S_IDLE;
		endcase
	end

	assign ack_o = (state == S_IDLE);
	assign start = ack_o & stb_i;
	assign stb_o = (state == S_WAIT) & ready;
	assign busy_o = (state == S_WAIT);

endmodule

// File: design/tmu_vdiv_top.sv
// vertex division front end, operand stage followed by division stage.
// up to two squares in flight, about 18 cycles from input to output strobe.
// back-pressure on ack_i holds the output, then fills the operand slot.
`timescale 1ns/1ps

module tmu_vdiv_top (
	input  logic               sys_clk,
	input  logic               sys_rst,

	input  logic               stb_i,
	output logic               ack_o,
	input  tmu_pkg::square_t   sq_i,

	output logic               stb_o,
	input  logic               ack_i,
	output tmu_pkg::vdiv_res_t res_o,

	output logic               busy_o
);

	logic              ops_stb;
	logic              ops_ack;
	tmu_pkg::vdivops_t ops;
	logic              div_busy;

	// sign and magnitude of the vertical differences.
	tmu_vdivops u_vdivops (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.stb_i   (stb_i),
		.ack_o   (ack_o),
		.sq_i    (sq_i),
		.stb_o   (ops_stb),
		.ack_i   (ops_ack),
		.ops_o   (ops)
	);

	// per line steps.
	tmu_vdiv u_vdiv (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.busy_o  (div_busy),
		.stb_i   (ops_stb),
		.ack_o   (ops_ack),
		.ops_i   (ops),
		.stb_o   (stb_o),
		.ack_i   (ack_i),
		.res_o   (res_o)
	);

	// a square waiting in the operand slot counts as busy too.
	assign busy_o = div_busy | ops_stb;

endmodule

// File: test/tb_tmu_vdiv.sv
// testbench for the vertex division front end, run from the project root.
// cases and expected steps come from test/vdiv_cases.txt.
// ack_i is stalled at random by a seeded LCG.
`timescale 1ns/1ps

module tb_tmu_vdiv;

	logic               sys_clk;
	logic               sys_rst;
	logic               stb_i;
	logic               ack_o;
	tmu_pkg::square_t   sq_i;
	logic               stb_o;
	logic               ack_i = 1'b0;
	tmu_pkg::vdiv_res_t res_o;
	logic               busy_o;

	tmu_pkg::square_t   sq_q[$];
	tmu_pkg::vdiv_res_t exp_q[$];
	tmu_pkg::height_t   h_q[$];
	tmu_pkg::vdiv_res_t held_res;
	logic               held_valid = 1'b0;
	logic [31:0]        lcg_state = 32'd93;
	int                 errors = 0;
	int                 in_count = 0;
	int                 out_count = 0;
	int                 cycles = 0;
	int                 limit = 0;

	tmu_vdiv_top u_dut (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.stb_i   (stb_i),
		.ack_o   (ack_o),
		.sq_i    (sq_i),
		.stb_o   (stb_o),
		.ack_i   (ack_i),
		.res_o   (res_o),
		.busy_o  (busy_o)
	);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic check_val(input string name, input logic [35:0] got, input logic [35:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// one quotient and remainder pair, plus the remainder bound.
	task automatic check_step(input string name, input tmu_pkg::divres_t got,
		input tmu_pkg::divres_t exp, input tmu_pkg::height_t h);
		check_val({name, ".positive"}, 36'(got.positive), 36'(exp.positive));
		check_val({name, ".q"}, 36'(got.q), 36'(exp.q));
		check_val({name, ".r"}, 36'(got.r), 36'(exp.r));
		assert (h == '0 || got.r < 17'(h)) else begin
			$display("%s remainder is not below the square height", name);
			errors++;
		end
	endtask

	task automatic load_cases();
		int                 fd;
		int                 n;
		int                 f[23];
		string              line;
		tmu_pkg::square_t   sq;
		tmu_pkg::vdiv_res_t ex;
		fd = $fopen("test/vdiv_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open test/vdiv_cases.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line.getc(0) != "#") begin
					n = $sscanf(line, "%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
						f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21],
						f[22]);
					if (n == 23) begin
						sq.a = '{x: tmu_pkg::coord_t'(f[0]), y: tmu_pkg::coord_t'(f[1])};
						sq.b = '{x: tmu_pkg::coord_t'(f[2]), y: tmu_pkg::coord_t'(f[3])};
						sq.c = '{x: tmu_pkg::coord_t'(f[4]), y: tmu_pkg::coord_t'(f[5])};
						sq.d = '{x: tmu_pkg::coord_t'(f[6]), y: tmu_pkg::coord_t'(f[7])};
						sq.drx = tmu_pkg::delta_t'(f[8]);
						sq.dry = tmu_pkg::delta_t'(f[9]);
						sq.squareh = tmu_pkg::height_t'(f[10]);
						// a, b and the deltas travel through unchanged.
						ex.a = sq.a;
						ex.b = sq.b;
						ex.drx = sq.drx;
						ex.dry = sq.dry;
						ex.cx = '{f[11][0], tmu_pkg::mag_t'(f[12]), tmu_pkg::mag_t'(f[13])};
						ex.cy = '{f[14][0], tmu_pkg::mag_t'(f[15]), tmu_pkg::mag_t'(f[16])};
						ex.dx = '{f[17][0], tmu_pkg::mag_t'(f[18]), tmu_pkg::mag_t'(f[19])};
						ex.dy = '{f[20][0], tmu_pkg::mag_t'(f[21]), tmu_pkg::mag_t'(f[22])};
						sq_q.push_back(sq);
						exp_q.push_back(ex);
						h_q.push_back(sq.squareh);
					end else begin
						$display("malformed line in the case file was skipped");
						errors++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic check_idle();
		check_val("stb_o", 36'(stb_o), 36'd0);
		check_val("busy_o", 36'(busy_o), 36'd0);
		check_val("ack_o", 36'(ack_o), 36'd1);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// output side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(posedge sys_clk) begin
		if (sys_rst) begin
			ack_i <= 1'b0;
		end else begin
			lcg_state = lcg_next(lcg_state);
			ack_i <= lcg_state[16];
		end
	end

	always @(negedge sys_clk) begin
		if (!sys_rst) begin
			check_val("busy_o", 36'(busy_o), 36'(in_count != out_count));
			if (stb_o) begin
				// a stalled result must not move.
				assert (!held_valid || res_o === held_res) else begin
					$display("[ERROR] res_o got %h expected %h", res_o, held_res);
					errors++;
				end
				assert (out_count < exp_q.size()) else begin
					$display("result appeared with no case left to match it");
					errors++;
				end
				if (ack_i && out_count < exp_q.size()) begin
					check_val("res_o.a", res_o.a, exp_q[out_count].a);
					check_val("res_o.b", res_o.b, exp_q[out_count].b);
					check_val("res_o.drx", 36'(res_o.drx), 36'(exp_q[out_count].drx));
					check_val("res_o.dry", 36'(res_o.dry), 36'(exp_q[out_count].dry));
					check_step("res_o.cx", res_o.cx, exp_q[out_count].cx, h_q[out_count]);
					check_step("res_o.cy", res_o.cy, exp_q[out_count].cy, h_q[out_count]);
					check_step("res_o.dx", res_o.dx, exp_q[out_count].dx, h_q[out_count]);
					check_step("res_o.dy", res_o.dy, exp_q[out_count].dy, h_q[out_count]);
					out_count++;
				end
				held_valid = !ack_i;
				held_res = res_o;
			end else begin
				assert (!held_valid) else begin
					$display("stb_o fell before the result was taken");
					errors++;
				end
				held_valid = 1'b0;
			end
		end
	end

	always @(posedge sys_clk) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("timeout, only %0d of %0d results arrived", out_count, exp_q.size());
			$display("TEST FAILED");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// input side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		sys_rst = 1'b1;
		stb_i = 1'b0;
		sq_i = '0;
		load_cases();
		limit = exp_q.size() * 60 + 200;
		if (exp_q.size() == 0) begin
			$display("no cases were loaded");
			$display("TEST FAILED");
			$finish;
		end else begin
			repeat (7) begin
				@(posedge sys_clk);
				@(negedge sys_clk);
				check_idle();
			end
			// eighth edge still sees reset high.
			@(posedge sys_clk);
			sys_rst <= 1'b0;
			@(negedge sys_clk);
			check_idle();
			@(posedge sys_clk);
			// back to back, each case held until taken.
			foreach (sq_q[i]) begin
				stb_i <= 1'b1;
				sq_i <= sq_q[i];
				@(negedge sys_clk);
				while (!ack_o) begin
					@(negedge sys_clk);
				end
				@(posedge sys_clk);
				in_count++;
			end
			stb_i <= 1'b0;
			while (out_count < exp_q.size()) begin
				@(posedge sys_clk);
			end
			repeat (20) @(posedge sys_clk);
			$display("errors: %0d, results %0d of %0d", errors, out_count, exp_q.size());
			if (errors == 0) begin
				$display("TEST PASSED");
			end else begin
				$display("TEST FAILED");
			end
			$finish;
		end
	end

endmodule

// File: test/vdiv_cases.txt
# in: ax ay bx by cx cy dx dy drx dry h, all decimal, coordinates and deltas signed
# out: positive q r for cx, cy, dx, dy in that order, steps of c-a and d-b by h
0 0 16 0 0 16 16 16 1 0 16 1 0 0 1 1 0 1 0 0 1 1 0
100 50 200 50 90 150 210 140 -3 5 7 0 1 3 1 14 2 1 1 3 1 12 6
5 5 9 5 2 20 9 1 7 -7 0 0 131071 3 1 131071 15 1 131071 0 0 131071 4
-100 -200 -50 -200 -300 -100 0 -400 0 0 1 0 200 0 1 100 0 1 50 0 0 200 0
-60000 60000 0 0 60000 -60000 65535 -65535 2047 -2048 2047 1 58 1274 0 58 1274 1 32 31 0 32 31
10 20 30 40 11 18 35 33 -1 -1 3 1 0 1 0 0 2 1 1 2 0 2 1
0 0 1000 0 -12345 99999 1000 100 100 -100 100 0 123 45 1 999 99 1 0 0 1 1 0
50000 -50000 -50000 50000 50000 30000 -100000 -30000 -2048 2047 1024 1 0 0 1 78 128 0 48 848 0 78 128
1 2 3 4 100 200 -100 -200 11 22 13 1 7 8 1 15 3 0 7 12 0 15 9
7 7 7 7 7 7 7 7 -5 3 0 1 131071 0 1 131071 0 1 131071 0 1 131071 0
-1 -1 2 2 -2 -1 100002 -99998 1000 -1000 2000 0 0 1 1 0 0 1 50 0 0 50 0
123 456 789 1011 1000 300 700 2000 9 -9 9 1 97 4 0 17 3 0 9 8 1 109 8
0 0 0 0 2046 -2046 -1 1 -2048 2047 2047 1 0 2046 0 0 2046 0 0 1 1 0 1

// File: sim.f
design/tmu_pkg.sv
design/tmu_divider17.sv
design/tmu_vdivops.sv
design/tmu_vdiv.sv
design/tmu_vdiv_top.sv
test/tb_tmu_vdiv.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f sim.f --top-module tb_tmu_vdiv -o tb_tmu_vdiv
./obj_dir/tb_tmu_vdiv > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
grep -q "TEST PASSED" sim.log
